//--- project.f
+incdir+include
design/priv_pkg.sv
design/irq_pkg.sv
design/irq_pending_unit.sv
design/priv_state_tracker.sv
design/int_controller.sv
design/irq_subsystem.sv
tb/tb_irq_subsystem.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_irq_subsystem \
  -f project.f -o sim_irq > build.log 2>&1 &&
./obj_dir/sim_irq 2>&1 | tee sim.log
grep -q "Simulation completed successfully" sim.log && exit 0 || exit 1

//--- tb/tb_irq_subsystem.sv
`include "irq_params.svh"

module tb_irq_subsystem
  import irq_pkg::*;
  import priv_pkg::*;
;

  //////////////////////////////
  // dut signals
  //////////////////////////////

  logic                clk;
  logic                rst_n;
  logic [`IRQ_NUM-1:0] irq_lines;
  logic [`IRQ_NUM-1:0] irq_mask;
  logic [`IRQ_NUM-1:0] irq_sec_map;
  logic                csr_wr;
  logic                csr_m_ie;
  logic                csr_u_ie;
  logic                enter_user;
  logic                mret;
  logic                ctrl_ack;
  logic                ctrl_kill;
  logic                irq_req;
  irq_id_t             irq_id;
  logic                irq_sec;
  logic                m_ie;
  logic                u_ie;
  priv_lvl_t           priv_lvl;

  // reference model state
  logic [`IRQ_NUM-1:0] m_pend;
  logic [`IRQ_NUM-1:0] m_clr;
  ctrl_state_t         m_state;
  irq_id_t             m_id;
  logic                m_sec;
  priv_lvl_t           m_lvl;
  priv_lvl_t           m_prev;
  logic                m_mie;
  logic                m_uie;
  logic                m_mpie;
  logic                m_upie;
  logic [31:0]         rng_state;

  irq_subsystem #(
    .PULP_SECURE (1'b1)
  ) i_dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .irq_lines_i   (irq_lines),
    .irq_mask_i    (irq_mask),
    .irq_sec_map_i (irq_sec_map),
    .csr_wr_i      (csr_wr),
    .csr_m_ie_i    (csr_m_ie),
    .csr_u_ie_i    (csr_u_ie),
    .enter_user_i  (enter_user),
    .mret_i        (mret),
    .ctrl_ack_i    (ctrl_ack),
    .ctrl_kill_i   (ctrl_kill),
    .irq_req_o     (irq_req),
    .irq_id_o      (irq_id),
    .irq_sec_o     (irq_sec),
    .m_ie_o        (m_ie),
    .u_ie_o        (u_ie),
    .priv_lvl_o    (priv_lvl)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //////////////////////////////
  // helpers
  //////////////////////////////

  // xorshift32 step
  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // lowest set bit wins
  function automatic irq_id_t lowest_index(input logic [`IRQ_NUM-1:0] vec);
    irq_id_t idx;
    bit      found;
    idx = '0;
    found = 1'b0;
    for (int i = 0; i < `IRQ_NUM; i++)
    begin
      if (vec[i] && !found)
      begin
        idx = irq_id_t'(i);
        found = 1'b1;
      end
    end
    return idx;
  endfunction

  // U mode takes u_ie or a secure line while M mode needs m_ie
  function automatic logic irq_allowed(input priv_lvl_t lvl, input logic mie,
                                       input logic uie, input logic sec);
    if (lvl == PRIV_LVL_U)
    begin
      return uie | sec;
    end
    return mie & (lvl == PRIV_LVL_M);
  endfunction

  task automatic report_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    $display("FAILED %s got 0x%0h expected 0x%0h (model state %s)",
             name, got, exp, m_state.name());
    $display("Simulation failed");
    $fatal(1, "value mismatch on %s", name);
  endtask

  task automatic report_error(input string what);
    $display("ERROR %s", what);
    $display("Simulation failed");
    $fatal(1, "%s", what);
  endtask

  //////////////////////////////
  // reference model
  //////////////////////////////

  // served bit goes away during the done cycle
  assign m_clr = (m_state == IRQ_DONE) ? (32'd1 << m_id) : '0;

  always @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      m_pend  <= '0;
      m_state <= IDLE;
      m_id    <= '0;
      m_sec   <= 1'b0;
      m_lvl   <= PRIV_LVL_M;
      m_prev  <= PRIV_LVL_M;
      m_mie   <= 1'b0;
      m_uie   <= 1'b0;
      m_mpie  <= 1'b0;
      m_upie  <= 1'b0;
    end
    else
    begin
      m_pend <= (m_pend & ~m_clr) | (irq_lines & irq_mask);
      case (m_state)
        IDLE:
        begin
          if (m_pend != '0 &&
              irq_allowed(m_lvl, m_mie, m_uie, irq_sec_map[lowest_index(m_pend)]))
          begin
            m_state <= IRQ_PENDING;
            m_id    <= lowest_index(m_pend);
            m_sec   <= irq_sec_map[lowest_index(m_pend)];
          end
        end
        IRQ_PENDING:
        begin
          if (ctrl_ack)
          begin
            m_state <= IRQ_DONE;
          end
          else if (ctrl_kill)
          begin
            m_state <= IDLE;
          end
        end
        default:
        begin
          m_state <= IDLE;
          m_sec   <= 1'b0;
        end
      endcase
      // trap is raised by the done cycle itself
      if (m_state == IRQ_DONE)
      begin
        m_mpie <= m_mie;
        m_upie <= m_uie;
        m_mie  <= 1'b0;
        m_prev <= m_lvl;
        m_lvl  <= PRIV_LVL_M;
      end
      else if (mret)
      begin
        m_mie  <= m_mpie;
        m_uie  <= m_upie;
        m_lvl  <= m_prev;
        m_prev <= PRIV_LVL_U;
      end
      else if (csr_wr)
      begin
        m_mie <= csr_m_ie;
        m_uie <= csr_u_ie;
      end
      else if (enter_user)
      begin
        m_lvl <= PRIV_LVL_U;
      end
    end
  end

  // outputs are settled by the falling edge
  always @(negedge clk)
  begin
    if (rst_n)
    begin
      assert (irq_req == (m_state == IRQ_PENDING))
        else report_value("irq_req_o", 32'(irq_req), 32'(m_state == IRQ_PENDING));
      assert (irq_id == m_id)
        else report_value("irq_id_o", 32'(irq_id), 32'(m_id));
      assert (irq_sec == m_sec)
        else report_value("irq_sec_o", 32'(irq_sec), 32'(m_sec));
      assert (m_ie == m_mie)
        else report_value("m_ie_o", 32'(m_ie), 32'(m_mie));
      assert (u_ie == m_uie)
        else report_value("u_ie_o", 32'(u_ie), 32'(m_uie));
      assert (priv_lvl == m_lvl)
        else report_value("priv_lvl_o", 32'(priv_lvl), 32'(m_lvl));
    end
  end

  //////////////////////////////
  // stimulus tasks
  //////////////////////////////

  // called on a falling edge
  task automatic wait_for_request(input int limit);
    int cycles;
    cycles = 0;
    while (!irq_req && cycles < limit)
    begin
      @(negedge clk);
      cycles++;
    end
    if (!irq_req)
    begin
      report_error("no interrupt request arrived within the timeout");
    end
  endtask

  // one-cycle pulse so the line only leaves its pending bit behind
  task automatic pulse_lines(input logic [`IRQ_NUM-1:0] pattern);
    @(posedge clk);
    irq_lines <= pattern;
    @(posedge clk);
    irq_lines <= '0;
    @(negedge clk);
  endtask

  task automatic write_enables(input logic mie, input logic uie);
    @(posedge clk);
    csr_wr   <= 1'b1;
    csr_m_ie <= mie;
    csr_u_ie <= uie;
    @(posedge clk);
    csr_wr   <= 1'b0;
    @(negedge clk);
  endtask

  // ack, let the trap land, then return with mret
  task automatic serve_request();
    @(posedge clk);
    ctrl_ack <= 1'b1;
    @(posedge clk);
    ctrl_ack <= 1'b0;
    @(posedge clk);
    mret     <= 1'b1;
    @(posedge clk);
    mret     <= 1'b0;
    @(negedge clk);
  endtask

  task automatic kill_request();
    @(posedge clk);
    ctrl_kill <= 1'b1;
    @(posedge clk);
    ctrl_kill <= 1'b0;
    @(negedge clk);
  endtask

  //////////////////////////////
  // test sequence
  //////////////////////////////

  initial
  begin
    int guard;
    rng_state   = 32'd53270;
    rst_n       = 1'b0;
    irq_lines   = '0;
    // line 20 stays masked and line 4 is the only secure one
    irq_mask    = 32'hFFEF_FFFF;
    irq_sec_map = 32'h0000_0010;
    csr_wr      = 1'b0;
    csr_m_ie    = 1'b0;
    csr_u_ie    = 1'b0;
    enter_user  = 1'b0;
    mret        = 1'b0;
    ctrl_ack    = 1'b0;
    ctrl_kill   = 1'b0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);

    // single request, ack, mret
    write_enables(1'b1, 1'b0);
    pulse_lines(32'h0000_0100);
    wait_for_request(10);
    serve_request();

    // random groups drain lowest first
    for (int round = 0; round < 6; round++)
    begin
      pulse_lines(next_random() & next_random() & next_random());
      guard = 0;
      while (m_pend != '0 && guard < 40)
      begin
        wait_for_request(10);
        serve_request();
        guard++;
      end
      if (m_pend != '0)
      begin
        report_error("pending lines did not drain within the service limit");
      end
    end

    // kill keeps the bit so the same id comes back
    pulse_lines(32'h0000_0080);
    wait_for_request(10);
    kill_request();
    wait_for_request(10);
    serve_request();

    // masked line stays silent
    pulse_lines(32'h0010_0000);
    repeat (10) @(negedge clk);

    // pending line waits for m_ie
    write_enables(1'b0, 1'b0);
    pulse_lines(32'h0000_0008);
    repeat (8) @(negedge clk);
    write_enables(1'b1, 1'b0);
    wait_for_request(10);
    serve_request();

    // in user mode only the secure line gets through
    @(posedge clk);
    enter_user <= 1'b1;
    @(posedge clk);
    enter_user <= 1'b0;
    pulse_lines(32'h0000_0200);
    repeat (8) @(negedge clk);
    pulse_lines(32'h0000_0010);
    wait_for_request(10);
    serve_request();
    repeat (6) @(negedge clk);
    write_enables(1'b1, 1'b1);
    wait_for_request(10);
    serve_request();
    repeat (4) @(negedge clk);

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

//--- design/irq_subsystem.sv
`include "irq_params.svh"

module irq_subsystem
  import irq_pkg::*;
  import priv_pkg::*;
#(
  parameter bit PULP_SECURE = 1'b1
)
(
  input  logic                clk,
  input  logic                rst_n,

  // interrupt lines and their attributes
  input  logic [`IRQ_NUM-1:0] irq_lines_i,
  input  logic [`IRQ_NUM-1:0] irq_mask_i,
  input  logic [`IRQ_NUM-1:0] irq_sec_map_i,

  // csr and privilege controls
  input  logic                csr_wr_i,
  input  logic                csr_m_ie_i,
  input  logic                csr_u_ie_i,
  input  logic                enter_user_i,
  input  logic                mret_i,

  // core handshake
  input  logic                ctrl_ack_i,
  input  logic                ctrl_kill_i,
  output logic                irq_req_o,
  output irq_id_t             irq_id_o,
  output logic                irq_sec_o,

  // observed privilege state
  output logic                m_ie_o,
  output logic                u_ie_o,
  output priv_lvl_t           priv_lvl_o
);

  //////////////////////////////
  // internal nets
  //////////////////////////////

  // pending unit to controller
  logic    sel_valid;
  irq_id_t sel_id;
  logic    sel_sec;
  // controller back to pending unit
  logic    clr_valid;
  irq_id_t clr_id;
  // controller to tracker
  logic    trap;

  irq_pending_unit i_pending (
    .clk           (clk),
    .rst_n         (rst_n),
    .irq_lines_i   (irq_lines_i),
    .irq_mask_i    (irq_mask_i),
    .irq_sec_map_i (irq_sec_map_i),
    .clr_valid_i   (clr_valid),
    .clr_id_i      (clr_id),
    .sel_valid_o   (sel_valid),
    .sel_id_o      (sel_id),
    .sel_sec_o     (sel_sec)
  );

  // enables feed both the controller and the top outputs
  priv_state_tracker i_priv (
    .clk          (clk),
    .rst_n        (rst_n),
    .csr_wr_i     (csr_wr_i),
    .csr_m_ie_i   (csr_m_ie_i),
    .csr_u_ie_i   (csr_u_ie_i),
    .enter_user_i (enter_user_i),
    .trap_i       (trap),
    .mret_i       (mret_i),
    .m_ie_o       (m_ie_o),
    .u_ie_o       (u_ie_o),
    .priv_lvl_o   (priv_lvl_o)
  );

  int_controller #(
    .PULP_SECURE (PULP_SECURE)
  ) i_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .sel_valid_i (sel_valid),
    .sel_id_i    (sel_id),
    .sel_sec_i   (sel_sec),
    .m_ie_i      (m_ie_o),
    .u_ie_i      (u_ie_o),
    .priv_lvl_i  (priv_lvl_o),
    .ctrl_ack_i  (ctrl_ack_i),
    .ctrl_kill_i (ctrl_kill_i),
    .irq_req_o   (irq_req_o),
    .irq_sec_o   (irq_sec_o),
    .irq_id_o    (irq_id_o),
    .clr_valid_o (clr_valid),
    .clr_id_o    (clr_id),
    .trap_o      (trap)
  );

endmodule

//--- design/int_controller.sv
`include "irq_params.svh"

module int_controller
  import irq_pkg::*;
  import priv_pkg::*;
#(
  parameter bit PULP_SECURE = 1'b1
)
(
  input  logic      clk,
  input  logic      rst_n,

  // selection from the pending unit
  input  logic      sel_valid_i,
  input  irq_id_t   sel_id_i,
  input  logic      sel_sec_i,

  // enables and level from the privilege tracker
  input  logic      m_ie_i,
  input  logic      u_ie_i,
  input  priv_lvl_t priv_lvl_i,

  // core side, plain level request with ack and kill pulses
  input  logic      ctrl_ack_i,
  input  logic      ctrl_kill_i,
  output logic      irq_req_o,
  output logic      irq_sec_o,
  output irq_id_t   irq_id_o,

  // served line back to the pending unit
  output logic      clr_valid_o,
  output irq_id_t   clr_id_o,

  // trap entry toward the privilege tracker
  output logic      trap_o
);

  //////////////////////////////
  // enable gating
  //////////////////////////////

  logic irq_enable;

  // secure lines reach the core in U mode even with u_ie off
  if (PULP_SECURE)
  begin : g_secure
    assign irq_enable = ((u_ie_i | sel_sec_i) & (priv_lvl_i == PRIV_LVL_U)) |
                        (m_ie_i & (priv_lvl_i == PRIV_LVL_M));
  end
  else
  begin : g_plain
    // single global enable
    assign irq_enable = m_ie_i;
  end

  //////////////////////////////
  // request fsm
  //////////////////////////////

  ctrl_state_t state_q;
  ctrl_state_t state_d;
  irq_id_t     id_q;
  logic        sec_q;

  always_comb
  begin
    state_d = state_q;
    unique case (state_q)
      IDLE:
      begin
        if (sel_valid_i && irq_enable)
        begin
          state_d = IRQ_PENDING;
        end
      end
      IRQ_PENDING:
      begin
        // ack wins over kill, neither means hold
        if (ctrl_ack_i)
        begin
          state_d = IRQ_DONE;
        end
        else if (ctrl_kill_i)
        begin
          state_d = IDLE;
        end
      end
      IRQ_DONE:
      begin
        state_d = IDLE;
      end
      default:
      begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= IDLE;
      id_q    <= '0;
      sec_q   <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      // capture the winner on the way into IRQ_PENDING
      if (state_q == IDLE && state_d == IRQ_PENDING)
      begin
        id_q  <= sel_id_i;
        sec_q <= sel_sec_i;
      end
      else if (state_q == IRQ_DONE)
      begin
        sec_q <= 1'b0;
      end
    end
  end

  // request only while pending
  assign irq_req_o   = (state_q == IRQ_PENDING);
  assign irq_sec_o   = sec_q;
  assign irq_id_o    = id_q;

  // IRQ_DONE is a single cycle, so these are one-cycle pulses
  assign clr_valid_o = (state_q == IRQ_DONE);
  assign clr_id_o    = id_q;
  assign trap_o      = (state_q == IRQ_DONE);

endmodule

//--- design/priv_state_tracker.sv
`include "irq_params.svh"

module priv_state_tracker
  import priv_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,

  // software write of the enable bits
  input  logic      csr_wr_i,
  input  logic      csr_m_ie_i,
  input  logic      csr_u_ie_i,

  // drop to user mode
  input  logic      enter_user_i,

  // trap entry from the controller, return from the testbench
  input  logic      trap_i,
  input  logic      mret_i,

  // current state toward the controller
  output logic      m_ie_o,
  output logic      u_ie_o,
  output priv_lvl_t priv_lvl_o
);

  //////////////////////////////
  // mstatus-like state
  //////////////////////////////

  priv_lvl_t priv_lvl_q;
  // level to return to on mret, like mpp
  priv_lvl_t priv_prev_q;
  // live enables
  logic      m_ie_q;
  logic      u_ie_q;
  // enables saved on trap entry, like mpie and upie
  logic      m_pie_q;
  logic      u_pie_q;

  // update priority is trap, mret, csr write, enter user
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      // machine mode with interrupts off out of reset
      priv_lvl_q  <= PRIV_LVL_M;
      priv_prev_q <= PRIV_LVL_M;
      m_ie_q      <= 1'b0;
      u_ie_q      <= 1'b0;
      m_pie_q     <= 1'b0;
      u_pie_q     <= 1'b0;
    end
    else if (trap_i)
    begin
      // stash both enables so mret returns to the pre-trap state
      m_pie_q     <= m_ie_q;
      u_pie_q     <= u_ie_q;
      // no nesting, the handler runs with m_ie off
      m_ie_q      <= 1'b0;
      // remember where we came from, then go to M
      priv_prev_q <= priv_lvl_q;
      priv_lvl_q  <= PRIV_LVL_M;
    end
    else if (mret_i)
    begin
      // restore the enables saved at trap entry
      m_ie_q      <= m_pie_q;
      u_ie_q      <= u_pie_q;
      priv_lvl_q  <= priv_prev_q;
      // the prior level drops back to U as in the spec for mpp
      priv_prev_q <= PRIV_LVL_U;
    end
    else if (csr_wr_i)
    begin
      m_ie_q <= csr_m_ie_i;
      u_ie_q <= csr_u_ie_i;
    end
    else if (enter_user_i)
    begin
      priv_lvl_q <= PRIV_LVL_U;
    end
  end

  assign m_ie_o     = m_ie_q;
  assign u_ie_o     = u_ie_q;
  assign priv_lvl_o = priv_lvl_q;

endmodule

//--- design/irq_pending_unit.sv
`include "irq_params.svh"

module irq_pending_unit
  import irq_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,

  // raw level-triggered lines and their per-line attributes
  input  logic [`IRQ_NUM-1:0] irq_lines_i,
  input  logic [`IRQ_NUM-1:0] irq_mask_i,
  input  logic [`IRQ_NUM-1:0] irq_sec_map_i,

  // clear of the served line from the controller
  input  logic                clr_valid_i,
  input  irq_id_t             clr_id_i,

  // winning pending line
  output logic                sel_valid_o,
  output irq_id_t             sel_id_o,
  output logic                sel_sec_o
);

  //////////////////////////////
  // pending register
  //////////////////////////////

  logic [`IRQ_NUM-1:0] pend_q;
  logic [`IRQ_NUM-1:0] pend_d;
  // lines that may set a bit this cycle
  logic [`IRQ_NUM-1:0] set_vec;
  // one-hot of the line being cleared
  logic [`IRQ_NUM-1:0] clr_vec;

  // mask gates only the setting of a bit
  // bits already pending stay until served
  assign set_vec = irq_lines_i & irq_mask_i;

  // decode the clear id into a one-hot vector
  assign clr_vec = clr_valid_i ? ({{(`IRQ_NUM-1){1'b0}}, 1'b1} << clr_id_i)
                               : '0;

  // clear first, then set
  // a line still held high re-arms its bit in the same cycle
  assign pend_d = (pend_q & ~clr_vec) | set_vec;

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      pend_q <= '0;
    end
    else
    begin
      pend_q <= pend_d;
    end
  end

  //////////////////////////////
  // priority select
  //////////////////////////////

  // fixed priority, the lowest set index wins
  // scan downward so the last hit is the lowest index
  always_comb
  begin
    sel_id_o = '0;
    for (int i = `IRQ_NUM-1; i >= 0; i--)
    begin
      if (pend_q[i])
      begin
        sel_id_o = irq_id_t'(i);
      end
    end
  end

  // any pending bit makes a valid selection
  assign sel_valid_o = |pend_q;

  // secure attribute of the selected line
  // don't care when nothing is pending, index 0 is read then
  assign sel_sec_o = irq_sec_map_i[sel_id_o];

endmodule

//--- design/irq_pkg.sv
`include "irq_params.svh"

package irq_pkg;

  //////////////////////////////
  // interrupt types
  //////////////////////////////

  // index of one interrupt line, 0 is the highest priority
  typedef logic [`IRQ_ID_W-1:0] irq_id_t;

  // request state machine toward the core
  typedef enum logic [1:0] {
    // waiting for an enabled pending line
    IDLE        = 2'b00,
    // request held high until ack or kill
    IRQ_PENDING = 2'b01,
    // one cycle to clear the served bit and enter the trap
    IRQ_DONE    = 2'b10
  } ctrl_state_t;

  // 2'b11 is unused and falls back to IDLE in the controller

endpackage

//--- design/priv_pkg.sv
package priv_pkg;

  //////////////////////////////
  // privilege levels
  //////////////////////////////

  // encodings follow the riscv mstatus.mpp field
  // only user and machine mode exist here, supervisor is not modelled
  typedef enum logic [1:0] {
    // user mode, lowest privilege
    PRIV_LVL_U = 2'b00,
    // machine mode, reset level and trap target
    PRIV_LVL_M = 2'b11
  } priv_lvl_t;

  // the tracker holds one current and one prior level of this type
  // the controller reads the current level for enable gating
  // a level of 2'b01 or 2'b10 is never produced by the tracker

  // levels compare directly with ==, no ordering helper needed
  // since only two levels are in use

endpackage

//--- include/irq_params.svh
`ifndef IRQ_PARAMS_SVH
`define IRQ_PARAMS_SVH

//////////////////////////////
// interrupt subsystem sizing
//////////////////////////////

// number of level-triggered interrupt lines
// one pending bit and one mask bit per line
`define IRQ_NUM 32

// width of an interrupt index
// must cover IRQ_NUM-1, so log2 of the line count
`define IRQ_ID_W 5

// a line count above 2**IRQ_ID_W would need a wider id,
// keep both values in step when resizing

`endif
